// File: include/strob_macros.svh
`ifndef STROB_MACROS_SVH
`define STROB_MACROS_SVH

// strob1 length in clocks, one per cycle state
// ss11 is the shortest state, ss15 the longest
`define STROB1_1_TICKS 3
`define STROB1_2_TICKS 4
`define STROB1_3_TICKS 5
`define STROB1_4_TICKS 6
`define STROB1_5_TICKS 7

// strob2 only appears in the short states ss11 and ss12
`define STROB2_TICKS 3

// got closes every cycle
`define GOT_TICKS 2

// flip-flops between an asynchronous pin and its first use
`define SYNC_STAGES 2

`endif

// File: hdl/cycle_pkg.sv
`default_nettype none

package cycle_pkg;

  // requested next state as presented by the microcode
  // codes 1 to 5 pick ss11 to ss15, anything else falls back to ss11
  typedef logic [2:0] state_code_t;

  // one-hot state vector, bit 0 is ss11
  typedef logic [4:0] ss_t;

  // current processor cycle state
  // encoding equals the bit position in ss_t
  typedef enum logic [2:0] {
    st_ss11 = 3'd0,
    st_ss12 = 3'd1,
    st_ss13 = 3'd2,
    st_ss14 = 3'd3,
    st_ss15 = 3'd4
  } cycle_state_e;

endpackage

`default_nettype wire

// File: hdl/timing_pkg.sv
`default_nettype none

package timing_pkg;

  // remaining clocks of a one-shot pulse
  typedef logic [3:0] tick_t;

  // phases of one processor cycle in the strobe sequencer
  typedef enum logic [2:0] {
    ph_idle    = 3'd0,
    ph_wait_ok = 3'd1,
    ph_s1      = 3'd2,
    ph_hold    = 3'd3,
    ph_gap     = 3'd4,
    ph_s2      = 3'd5,
    ph_got     = 3'd6
  } phase_e;

endpackage

`default_nettype wire

// File: hdl/strob_if.sv
`timescale 1ns/1ps
`default_nettype none

// strobes and cycle state shared by the sequencer and the state register
interface strob_if;
  import cycle_pkg::*;

  // one-hot current state
  ss_t  ss;
  logic strob1;
  logic strob2;
  logic got;
  // single clock pulse on the last clock of got
  logic got_end;

  // strobe sequencer
  modport gen (
    input  ss,
    output strob1,
    output strob2,
    output got,
    output got_end
  );

  // state register
  modport seq (
    output ss,
    input  got_end
  );

endinterface

`default_nettype wire

// File: hdl/univib.sv
`timescale 1ns/1ps
`default_nettype none

// one-shot pulse of a fixed number of clocks
// a start that arrives while the pulse runs has no effect
module univib #(
  parameter timing_pkg::tick_t ticks = 4'd1
) (
  input  logic __clk,
  input  logic arst_n,
  input  logic start,
  output logic q
);
  import timing_pkg::*;

  tick_t cnt;

  always_ff @(posedge __clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (start && cnt == '0) begin
      cnt <= ticks;
    end else if (cnt != '0) begin
      cnt <= cnt - tick_t'(1);
    end
  end

  // high for exactly ticks clocks after the start edge
  assign q = (cnt != '0);

endmodule

`default_nettype wire

// File: hdl/panel_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "strob_macros.svh"

module panel_sync (
  input  logic __clk,
  input  logic arst_n,
  input  logic ok,
  input  logic zw,
  input  logic oken,
  input  logic mode,
  input  logic step_,
  input  logic strob_fp_,
  output logic ok_s,
  output logic busy_s,
  output logic mode_s,
  output logic step_fall,
  output logic fp_s
);

  // bit positions in the raw input vector
  localparam int b_ok    = 0;
  localparam int b_zw    = 1;
  localparam int b_oken  = 2;
  localparam int b_mode  = 3;
  localparam int b_step  = 4;
  localparam int b_fp    = 5;

  // active-low panel lines rest high
  localparam logic [5:0] idle_level = 6'b110000;

  logic [5:0] raw;
  logic [5:0] stage [`SYNC_STAGES];
  logic [5:0] synced;
  logic       step_n_d;

  assign raw = {strob_fp_, step_, mode, oken, zw, ok};

  always_ff @(posedge __clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        stage[i] <= idle_level;
      end
      step_n_d <= 1'b1;
    end else begin
      stage[0] <= raw;
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
      step_n_d <= synced[b_step];
    end
  end

  assign synced = stage[`SYNC_STAGES-1];

  assign ok_s   = synced[b_ok];
  // bus request only counts while it is enabled
  assign busy_s = synced[b_zw] & synced[b_oken];
  assign mode_s = synced[b_mode];
  assign fp_s   = ~synced[b_fp];

  // high to low on the synchronized step_ line
  assign step_fall = step_n_d & ~synced[b_step];

endmodule

`default_nettype wire

// File: hdl/strob_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "strob_macros.svh"

module strob_gen (
  input  logic __clk,
  input  logic arst_n,
  input  logic ok_s,
  input  logic busy_s,
  input  logic mode_s,
  input  logic step_fall,
  input  logic fp_s,
  strob_if.gen bus
);
  import timing_pkg::*;

  // strob1 lengths indexed by the one-hot state bit
  localparam tick_t [4:0] s1_ticks = {
    tick_t'(`STROB1_5_TICKS),
    tick_t'(`STROB1_4_TICKS),
    tick_t'(`STROB1_3_TICKS),
    tick_t'(`STROB1_2_TICKS),
    tick_t'(`STROB1_1_TICKS)
  };

  phase_e     phase;
  phase_e     phase_nx;
  logic       hold_q;
  logic       hold_nx;
  logic       got_r;
  logic       s1_go;
  logic       s2_go;
  logic       got_go;
  logic [4:0] s1_q;
  logic       s1_sel;
  logic       s2_q;
  logic       got_q;
  logic       need_ok;
  logic       short_cyc;
  logic       got_last;

  // one strob1 timer per state, only the selected one is started
  for (genvar i = 0; i < 5; i++) begin : g_s1
    univib #(
      .ticks (s1_ticks[i])
    ) u_s1 (
      .__clk  (__clk),
      .arst_n (arst_n),
      .start  (s1_go & bus.ss[i]),
      .q      (s1_q[i])
    );
  end

  univib #(
    .ticks (tick_t'(`STROB2_TICKS))
  ) u_s2 (
    .__clk  (__clk),
    .arst_n (arst_n),
    .start  (s2_go),
    .q      (s2_q)
  );

  univib #(
    .ticks (tick_t'(`GOT_TICKS))
  ) u_got (
    .__clk  (__clk),
    .arst_n (arst_n),
    .start  (got_go),
    .q      (got_q)
  );

  assign s1_sel    = |(s1_q & bus.ss);
  // ss12 and ss13 access memory and need ok first
  assign need_ok   = bus.ss[1] | bus.ss[2];
  assign short_cyc = bus.ss[0] | bus.ss[1];
  // got is the timer delayed by one clock, so its last clock is visible
  assign got_last  = got_r & ~got_q;

  always_comb begin
    phase_nx = phase;
    hold_nx  = hold_q;
    s1_go    = 1'b0;
    s2_go    = 1'b0;
    got_go   = 1'b0;
    case (phase)
      ph_idle, ph_wait_ok: begin
        if (!need_ok || ok_s) begin
          s1_go    = 1'b1;
          phase_nx = ph_s1;
        end else begin
          phase_nx = ph_wait_ok;
        end
      end
      ph_s1: begin
        if (s1_sel) begin
          // arm the hold before the timer runs out so strob1 stays high
          if (mode_s) begin
            hold_nx = 1'b1;
          end
        end else if (hold_q) begin
          phase_nx = ph_hold;
        end else if (short_cyc) begin
          phase_nx = ph_gap;
        end else if (!busy_s) begin
          got_go   = 1'b1;
          phase_nx = ph_got;
        end
      end
      ph_hold: begin
        // back through ph_s1 so strob1 gets one low clock before what follows
        if (step_fall) begin
          hold_nx  = 1'b0;
          phase_nx = ph_s1;
        end
      end
      ph_gap: begin
        s2_go    = 1'b1;
        phase_nx = ph_s2;
      end
      ph_s2: begin
        if (!s2_q && !busy_s) begin
          got_go   = 1'b1;
          phase_nx = ph_got;
        end
      end
      ph_got: begin
        if (got_last) begin
          phase_nx = ph_idle;
        end
      end
      default: begin
        phase_nx = ph_idle;
      end
    endcase
  end

  always_ff @(posedge __clk or negedge arst_n) begin
    if (!arst_n) begin
      phase  <= ph_idle;
      hold_q <= 1'b0;
      got_r  <= 1'b0;
    end else begin
      phase  <= phase_nx;
      hold_q <= hold_nx;
      got_r  <= got_q;
    end
  end

  // manual strobe from the panel overrides the sequence
  assign bus.strob1  = s1_sel | hold_q | fp_s;
  assign bus.strob2  = s2_q;
  assign bus.got     = got_r;
  assign bus.got_end = got_last;

endmodule

`default_nettype wire

// File: hdl/cycle_seq.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_seq (
  input  logic                   __clk,
  input  logic                   arst_n,
  input  cycle_pkg::state_code_t state_code,
  strob_if.seq                   bus
);
  import cycle_pkg::*;

  cycle_state_e state_q;
  cycle_state_e state_dec;

  // unused codes fall back to the shortest cycle
  always_comb begin
    case (state_code)
      3'd1:    state_dec = st_ss11;
      3'd2:    state_dec = st_ss12;
      3'd3:    state_dec = st_ss13;
      3'd4:    state_dec = st_ss14;
      3'd5:    state_dec = st_ss15;
      default: state_dec = st_ss11;
    endcase
  end

  // next state is taken on the last clock of got
  always_ff @(posedge __clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_ss11;
    end else if (bus.got_end) begin
      state_q <= state_dec;
    end
  end

  // enum value is the bit position
  assign bus.ss = ss_t'(1) << state_q;

endmodule

`default_nettype wire

// File: hdl/strob_unit.sv
`timescale 1ns/1ps
`default_nettype none

module strob_unit (
  input  logic                   __clk,
  input  logic                   arst_n,
  input  logic                   ok,
  input  logic                   zw,
  input  logic                   oken,
  input  logic                   mode,
  input  logic                   step_,
  input  logic                   strob_fp_,
  input  cycle_pkg::state_code_t state_code,
  output cycle_pkg::ss_t         ss,
  output logic                   strob1,
  output logic                   strob2,
  output logic                   got
);

  logic ok_s;
  logic busy_s;
  logic mode_s;
  logic step_fall;
  logic fp_s;

  strob_if bus ();

  panel_sync u_sync (
    .__clk     (__clk),
    .arst_n    (arst_n),
    .ok        (ok),
    .zw        (zw),
    .oken      (oken),
    .mode      (mode),
    .step_     (step_),
    .strob_fp_ (strob_fp_),
    .ok_s      (ok_s),
    .busy_s    (busy_s),
    .mode_s    (mode_s),
    .step_fall (step_fall),
    .fp_s      (fp_s)
  );

  strob_gen u_gen (
    .__clk     (__clk),
    .arst_n    (arst_n),
    .ok_s      (ok_s),
    .busy_s    (busy_s),
    .mode_s    (mode_s),
    .step_fall (step_fall),
    .fp_s      (fp_s),
    .bus       (bus.gen)
  );

  cycle_seq u_seq (
    .__clk      (__clk),
    .arst_n     (arst_n),
    .state_code (state_code),
    .bus        (bus.seq)
  );

  assign ss     = bus.ss;
  assign strob1 = bus.strob1;
  assign strob2 = bus.strob2;
  assign got    = bus.got;

endmodule

`default_nettype wire

// File: sim/strob_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "strob_macros.svh"

// strobe timing checks, bound into strob_unit
module strob_unit_properties (
  input logic                   __clk,
  input logic                   arst_n,
  input logic                   ok,
  input logic                   step_,
  input logic                   strob_fp_,
  input cycle_pkg::state_code_t state_code,
  input cycle_pkg::ss_t         ss,
  input logic                   strob1,
  input logic                   strob2,
  input logic                   got,
  input logic                   busy_s,
  input logic                   mode_s,
  input logic                   fp_s
);
  import cycle_pkg::*;

  int   fail_count = 0;
  logic [4:0] s1_run;

  // codes 1 to 5 select ss11 to ss15, all others ss11
  function automatic ss_t expect_ss(input state_code_t c);
    if (c >= 3'd1 && c <= 3'd5) begin
      return ss_t'(1) << (c - 3'd1);
    end
    return ss_t'(1);
  endfunction

  // consecutive clocks with strob1 high, saturating
  always_ff @(posedge __clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_run <= '0;
    end else if (!strob1) begin
      s1_run <= '0;
    end else if (s1_run != 5'h1f) begin
      s1_run <= s1_run + 5'd1;
    end
  end

  // strob1 width per state, only in free run without manual strobe
  a_s1_w1: assert property (@(posedge __clk) disable iff (!arst_n || mode_s || fp_s)
    $rose(strob1) && ss[0] |-> strob1[*`STROB1_1_TICKS] ##1 !strob1)
    else begin $error("FAIL strob1 width in ss=%h", ss); fail_count++; end
  a_s1_w2: assert property (@(posedge __clk) disable iff (!arst_n || mode_s || fp_s)
    $rose(strob1) && ss[1] |-> strob1[*`STROB1_2_TICKS] ##1 !strob1)
    else begin $error("FAIL strob1 width in ss=%h", ss); fail_count++; end
  a_s1_w3: assert property (@(posedge __clk) disable iff (!arst_n || mode_s || fp_s)
    $rose(strob1) && ss[2] |-> strob1[*`STROB1_3_TICKS] ##1 !strob1)
    else begin $error("FAIL strob1 width in ss=%h", ss); fail_count++; end
  a_s1_w4: assert property (@(posedge __clk) disable iff (!arst_n || mode_s || fp_s)
    $rose(strob1) && ss[3] |-> strob1[*`STROB1_4_TICKS] ##1 !strob1)
    else begin $error("FAIL strob1 width in ss=%h", ss); fail_count++; end
  a_s1_w5: assert property (@(posedge __clk) disable iff (!arst_n || mode_s || fp_s)
    $rose(strob1) && ss[4] |-> strob1[*`STROB1_5_TICKS] ##1 !strob1)
    else begin $error("FAIL strob1 width in ss=%h", ss); fail_count++; end

  // strob2 one gap clock after strob1 in the short states
  a_s2_seq: assert property (@(posedge __clk) disable iff (!arst_n)
    $fell(strob1) && !fp_s && !$past(fp_s) && (ss[0] || ss[1])
    |-> !strob2 ##1 !strob2 ##1 strob2[*`STROB2_TICKS] ##1 !strob2)
    else begin $error("FAIL strob2 sequence ss=%h strob2=%h", ss, strob2); fail_count++; end
  a_s2_long: assert property (@(posedge __clk) disable iff (!arst_n)
    strob2 |-> ss[0] || ss[1])
    else begin $error("FAIL strob2 in long state ss=%h", ss); fail_count++; end

  a_got_w: assert property (@(posedge __clk) disable iff (!arst_n)
    $rose(got) |-> got[*`GOT_TICKS] ##1 !got)
    else begin $error("FAIL got width got=%h", got); fail_count++; end
  a_got_busy: assert property (@(posedge __clk) disable iff (!arst_n)
    $rose(got) |-> !$past(busy_s, 2))
    else begin $error("FAIL got rose while busy_s=%h", $past(busy_s, 2)); fail_count++; end
  a_overlap: assert property (@(posedge __clk) disable iff (!arst_n)
    !fp_s |-> $onehot0({strob1, strob2, got}))
    else begin
      $error("FAIL strobe overlap {strob1,strob2,got}=%h", {strob1, strob2, got});
      fail_count++;
    end

  a_ss_hold: assert property (@(posedge __clk) disable iff (!arst_n)
    !$stable(ss) |-> $fell(got))
    else begin $error("FAIL ss changed outside got end ss=%h", ss); fail_count++; end
  a_ss_next: assert property (@(posedge __clk) disable iff (!arst_n)
    $fell(got) |-> ss == expect_ss($past(state_code)))
    else begin
      $error("FAIL ss=%h expected %h", ss, expect_ss($past(state_code)));
      fail_count++;
    end
  a_ok_wait: assert property (@(posedge __clk) disable iff (!arst_n)
    $rose(strob1) && !fp_s && (ss[1] || ss[2]) |-> $past(ok, `SYNC_STAGES + 1))
    else begin $error("FAIL strob1 rose without ok, ss=%h", ss); fail_count++; end

  // release from the step hold
  a_step: assert property (@(posedge __clk) disable iff (!arst_n)
    $fell(step_) && !fp_s && s1_run > 5'd8 |-> strob1[*(`SYNC_STAGES + 1)] ##1 !strob1)
    else begin $error("FAIL strob1=%h at step release", strob1); fail_count++; end
  a_fp: assert property (@(posedge __clk) disable iff (!arst_n)
    $fell(strob_fp_) |-> ##(`SYNC_STAGES) strob1)
    else begin $error("FAIL strob1=%h after manual strobe", strob1); fail_count++; end

endmodule

`default_nettype wire

// File: sim/strob_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module strob_unit_tb;
  import cycle_pkg::*;

  localparam int clk_limit = 60 * 40 + 6 * 80 + 400;

  logic        __clk;
  logic        arst_n;
  logic        ok;
  logic        zw;
  logic        oken;
  logic        mode;
  logic        step_;
  logic        strob_fp_;
  state_code_t state_code;
  ss_t         ss;
  logic        strob1;
  logic        strob2;
  logic        got;

  logic [31:0] rnd;
  int          clk_count;
  int          got_falls;
  logic        got_d;

  strob_unit dut0 (.*);

  bind strob_unit strob_unit_properties props0 (.*);

  initial begin
    __clk = 1'b0;
  end

  always #4 __clk = ~__clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // cycle counter by got falls, and the run limit
  always @(posedge __clk) begin
    clk_count <= clk_count + 1;
    got_d <= got;
    if (got_d && !got) begin
      got_falls <= got_falls + 1;
    end
    if (clk_count >= clk_limit) begin
      $display("timeout: the cycles did not complete within %0d clocks", clk_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic next_clock();
    @(posedge __clk);
    #1;
  endtask

  task automatic wait_got_fall();
    @(negedge got);
    next_clock();
  endtask

  // one cycle with random state, ok delay and bus request
  // ok goes low during got so a following ss12 or ss13 cycle has to wait for it
  task automatic free_cycle();
    int   ok_delay;
    int   busy_delay;
    int   i;
    logic seen_got;
    rnd = xorshift(rnd);
    state_code = rnd[2:0];
    ok_delay = rnd[5:3];
    busy_delay = rnd[10:8];
    zw = rnd[7];
    oken = rnd[11];
    i = 0;
    seen_got = 1'b0;
    while (!seen_got || got) begin
      if (i == ok_delay) ok = 1'b1;
      if (i == busy_delay) zw = 1'b0;
      next_clock();
      i++;
      if (got) begin
        seen_got = 1'b1;
        ok = 1'b0;
      end
    end
  endtask

  // wait for the hold, then release it with step_
  task automatic step_cycle(input logic last);
    int run;
    run = 0;
    while (run < 12) begin
      next_clock();
      run = strob1 ? run + 1 : 0;
    end
    rnd = xorshift(rnd);
    state_code = rnd[2:0];
    if (last) mode = 1'b0;
    step_ = 1'b0;
    repeat (3) next_clock();
    step_ = 1'b1;
    wait_got_fall();
  endtask

  initial begin
    rnd = 32'd46;
    clk_count = 0;
    got_falls = 0;
    got_d = 1'b0;
    arst_n = 1'b0;
    ok = 1'b0;
    zw = 1'b0;
    oken = 1'b0;
    mode = 1'b0;
    step_ = 1'b1;
    strob_fp_ = 1'b1;
    state_code = '0;
    repeat (5) @(posedge __clk);
    #1;
    arst_n = 1'b1;

    repeat (60) free_cycle();

    ok = 1'b1;
    mode = 1'b1;
    for (int i = 0; i < 6; i++) begin
      step_cycle(i == 5);
    end

    // a held bus request stalls the cycle before got, so strob1 rests low
    zw = 1'b1;
    oken = 1'b1;
    repeat (20) next_clock();
    for (int i = 0; i < 4; i++) begin
      strob_fp_ = 1'b0;
      repeat (3) next_clock();
      strob_fp_ = 1'b1;
      repeat (10 + i * 3) next_clock();
    end
    zw = 1'b0;
    repeat (20) next_clock();

    $display("assertion failures: %0d, cycles completed: %0d, clocks: %0d",
             dut0.props0.fail_count, got_falls, clk_count);
    if (dut0.props0.fail_count == 0 && got_falls >= 66) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: strob_unit.f
+incdir+include
hdl/cycle_pkg.sv
hdl/timing_pkg.sv
hdl/strob_if.sv
hdl/univib.sv
hdl/panel_sync.sv
hdl/strob_gen.sv
hdl/cycle_seq.sv
hdl/strob_unit.sv
sim/strob_unit_properties.sv
sim/strob_unit_tb.sv
